// File: lsu_pkg.sv
// Load/store unit shared definitions
package lsu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Access size codes (funct3)
    // Stores only look at the low two bits
    localparam logic [2:0] fn3_lb  = 3'b000;
    localparam logic [2:0] fn3_lh  = 3'b001;
    localparam logic [2:0] fn3_lw  = 3'b010;
    localparam logic [2:0] fn3_lbu = 3'b100;
    localparam logic [2:0] fn3_lhu = 3'b101;

    ////////////////////////////////////////////////////////////////////////////
    // Exception causes
    localparam logic [3:0] exc_load_misaligned  = 4'd4;
    localparam logic [3:0] exc_store_misaligned = 4'd6;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and sub-unit indices

    // Instruction tag width
    parameter int id_w = 3;

    localparam logic unit_scratch = 1'b0;
    localparam logic unit_bus     = 1'b1;

endpackage

// File: lsu_addr_map.sv
// Sub-unit address map
`timescale 1ns/1ps

module lsu_addr_map (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cfg_we,
    input  logic        cfg_sel,
    input  logic [31:0] cfg_wdata,
    input  logic [31:0] addr,
    output logic        unit_sel
);
    import lsu_pkg::*;

    logic [31:0] scratch_base;
    logic [31:0] bus_base;

    // cfg_sel picks the register: 0 scratch base, 1 bus base
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scratch_base <= 32'h0000_0000;
            bus_base     <= 32'h8000_0000;
        end else if (cfg_we) begin
            if (cfg_sel) begin
                bus_base <= cfg_wdata;
            end else begin
                scratch_base <= cfg_wdata;
            end
        end
    end

    // Everything from the bus base upwards belongs to the bus
    assign unit_sel = (addr >= bus_base) ? unit_bus : unit_scratch;

    // Scratch window must sit below the bus window
    base_order_check: assert property (
        @(posedge clk) disable iff (!arst_n)
        scratch_base < bus_base
    ) else $error("scratch base not below bus base");

endmodule

// File: lsu_issue_ctrl.sv
// Load/store issue control
`timescale 1ns/1ps

module lsu_issue_ctrl (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     issue_valid,
    input  logic                     load,
    input  logic                     store,
    input  logic [2:0]               fn3,
    input  logic [31:0]              rs1,
    input  logic [11:0]              offset,
    input  logic [31:0]              rs2,
    input  logic [lsu_pkg::id_w-1:0] id,
    output logic                     issue_ready,
    output logic                     exc_valid,
    output logic [3:0]               exc_code,
    output logic [31:0]              exc_tval,
    output logic [lsu_pkg::id_w-1:0] exc_id,
    output logic [31:0]              addr,
    input  logic                     unit_sel,
    input  logic                     bus_idle,
    input  logic                     fifo_full,
    input  logic                     fifo_empty,
    input  logic                     last_unit,
    output logic                     req_scratch,
    output logic                     req_bus,
    output logic                     req_we,
    output logic [3:0]               req_be,
    output logic [31:0]              req_wdata,
    output logic                     push
);
    import lsu_pkg::*;

    logic       accept;
    logic       mem_op;
    logic       misaligned;
    logic       unit_stall;
    logic       out_of_reset;
    logic [3:0] store_be;

    ////////////////////////////////////////////////////////////////////////////
    // Address and alignment
    assign addr = rs1 + {{20{offset[11]}}, offset};

    always_comb begin
        case (fn3[1:0])
            fn3_lh[1:0]: misaligned = addr[0];
            fn3_lw[1:0]: misaligned = |addr[1:0];
            default:     misaligned = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Byte enables and write lanes
    always_comb begin
        store_be  = 4'b0000;
        req_wdata = rs2;
        case (fn3[1:0])
            fn3_lb[1:0]: begin
                store_be[addr[1:0]] = 1'b1;
                req_wdata           = {4{rs2[7:0]}};
            end
            fn3_lh[1:0]: begin
                store_be  = addr[1] ? 4'b1100 : 4'b0011;
                req_wdata = {2{rs2[15:0]}};
            end
            default: store_be = 4'b1111;
        endcase
    end

    // Loads always read the whole word
    assign req_be = store ? store_be : 4'b1111;
    assign req_we = store;

    ////////////////////////////////////////////////////////////////////////////
    // Issue handshake

    // Held low until the first edge after reset release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_of_reset <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
        end
    end

    // Outstanding loads on the other unit could collide with this one
    assign unit_stall  = !fifo_empty && (unit_sel != last_unit);
    assign issue_ready = bus_idle && !fifo_full && !unit_stall && out_of_reset;

    assign accept = issue_valid && issue_ready;
    assign mem_op = accept && (load || store) && !misaligned;

    assign req_scratch = mem_op && (unit_sel == unit_scratch);
    assign req_bus     = mem_op && (unit_sel == unit_bus);
    assign push        = mem_op && load;

    // Misaligned accesses stop here
    assign exc_valid = accept && (load || store) && misaligned;
    assign exc_code  = store ? exc_store_misaligned : exc_load_misaligned;
    assign exc_tval  = addr;
    assign exc_id    = id;

    // An issued access is exactly one of load and store
    one_kind_check: assert property (
        @(posedge clk) disable iff (!arst_n)
        issue_valid |-> (load ^ store)
    ) else $error("issue is not exactly one of load and store");

endmodule

// File: lsu_load_fifo.sv
// Load attributes FIFO
`timescale 1ns/1ps

module lsu_load_fifo #(
    parameter int fifo_depth = 2
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     push,
    input  logic [2:0]               fn3_in,
    input  logic [1:0]               byte_off_in,
    input  logic [lsu_pkg::id_w-1:0] id_in,
    input  logic                     unit_in,
    input  logic                     pop,
    output logic [2:0]               fn3_out,
    output logic [1:0]               byte_off_out,
    output logic [lsu_pkg::id_w-1:0] id_out,
    output logic                     unit_out,
    output logic                     full,
    output logic                     empty,
    output logic                     last_unit
);
    import lsu_pkg::*;

    localparam int ptr_w   = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w   = $clog2(fifo_depth + 1);
    localparam int entry_w = 3 + 2 + id_w + 1;

    logic [entry_w-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {fn3_in, byte_off_in, id_in, unit_in};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            last_unit <= unit_scratch;
        end else begin
            if (push) begin
                wr_ptr    <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
                last_unit <= unit_in;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign {fn3_out, byte_off_out, id_out, unit_out} = mem[rd_ptr];

    assign full  = (count == cnt_w'(fifo_depth));
    assign empty = (count == '0);

    no_underflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        pop |-> !empty
    ) else $error("load completed with no load outstanding");

endmodule

// File: lsu_scratch_ram.sv
// Local scratch RAM
`timescale 1ns/1ps

module lsu_scratch_ram #(
    parameter int scratch_words = 256
) (
    input  logic        clk,
    input  logic        req,
    input  logic        we,
    input  logic [3:0]  be,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        rvalid
);
    localparam int idx_w = $clog2(scratch_words);

    logic [31:0]      mem [scratch_words];
    logic [idx_w-1:0] idx;

    // Word index, byte offset dropped
    assign idx = addr[idx_w+1:2];

    // Byte lane writes
    always_ff @(posedge clk) begin
        if (req && we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (req && !we) begin
            rdata <= mem[idx];
        end
        rvalid <= req && !we;
    end

endmodule

// File: lsu_bus_bridge.sv
// Four-phase bus bridge
`timescale 1ns/1ps

module lsu_bus_bridge (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        req,
    input  logic        we,
    input  logic [3:0]  be,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic        idle,
    output logic [31:0] rdata,
    output logic        rvalid,
    output logic        bus_req,
    output logic        bus_we,
    output logic [3:0]  bus_be,
    output logic [31:0] bus_addr,
    output logic [31:0] bus_wdata,
    input  logic        bus_ack,
    input  logic [31:0] bus_rdata
);
    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_request = 2'd1;
    localparam logic [1:0] st_release = 2'd2;
    localparam logic [1:0] st_return  = 2'd3;

    logic [1:0] state;

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    // Loads pass through return right after the ack, then wait for ack low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (req) state <= st_request;
                st_request: if (bus_ack) state <= bus_we ? st_release : st_return;
                st_return:  state <= st_release;
                st_release: if (!bus_ack) state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Access capture
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            bus_we    <= we;
            bus_be    <= be;
            bus_addr  <= {addr[31:2], 2'b00};
            bus_wdata <= wdata;
        end
        if (state == st_request && bus_ack) begin
            rdata <= bus_rdata;
        end
    end

    assign bus_req = (state == st_request);
    assign rvalid  = (state == st_return);
    assign idle    = (state == st_idle);

    // The memory only raises ack in answer to a request
    ack_after_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(bus_ack) |-> bus_req
    ) else $error("bus_ack rose without bus_req");

endmodule

// File: lsu_load_align.sv
// Load data alignment
`timescale 1ns/1ps

module lsu_load_align (
    input  logic [31:0]              scratch_rdata,
    input  logic                     scratch_rvalid,
    input  logic [31:0]              bus_rdata,
    input  logic                     bus_rvalid,
    input  logic [2:0]               fn3,
    input  logic [1:0]               byte_off,
    input  logic                     unit,
    input  logic [lsu_pkg::id_w-1:0] id,
    output logic                     wb_done,
    output logic [31:0]              wb_data,
    output logic [lsu_pkg::id_w-1:0] wb_id,
    output logic                     pop
);
    import lsu_pkg::*;

    logic [31:0] unit_data;
    logic [15:0] half_data;
    logic [7:0]  byte_data;

    // Data and valid of the unit at the FIFO head
    assign unit_data = (unit == unit_bus) ? bus_rdata : scratch_rdata;
    assign wb_done   = (unit == unit_bus) ? bus_rvalid : scratch_rvalid;

    // Halfword first, then byte within it
    assign half_data = byte_off[1] ? unit_data[31:16] : unit_data[15:0];
    assign byte_data = byte_off[0] ? half_data[15:8] : half_data[7:0];

    always_comb begin
        case (fn3)
            fn3_lb:  wb_data = {{24{byte_data[7]}}, byte_data};
            fn3_lh:  wb_data = {{16{half_data[15]}}, half_data};
            fn3_lbu: wb_data = {24'b0, byte_data};
            fn3_lhu: wb_data = {16'b0, half_data};
            fn3_lw:  wb_data = unit_data;
            default: wb_data = unit_data;
        endcase
    end

    assign wb_id = id;
    // Head entry retires with its writeback
    assign pop   = wb_done;

endmodule

// File: lsu_top.sv
// Load/store unit top level
`timescale 1ns/1ps

module lsu_top #(
    parameter int scratch_words = 256,
    parameter int fifo_depth    = 2
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     issue_valid,
    input  logic                     load,
    input  logic                     store,
    input  logic [2:0]               fn3,
    input  logic [31:0]              rs1,
    input  logic [11:0]              offset,
    input  logic [31:0]              rs2,
    input  logic [lsu_pkg::id_w-1:0] id,
    output logic                     issue_ready,
    output logic                     exc_valid,
    output logic [3:0]               exc_code,
    output logic [31:0]              exc_tval,
    output logic [lsu_pkg::id_w-1:0] exc_id,
    output logic                     wb_done,
    output logic [31:0]              wb_data,
    output logic [lsu_pkg::id_w-1:0] wb_id,
    output logic                     bus_req,
    output logic                     bus_we,
    output logic [3:0]               bus_be,
    output logic [31:0]              bus_addr,
    output logic [31:0]              bus_wdata,
    input  logic                     bus_ack,
    input  logic [31:0]              bus_rdata,
    input  logic                     cfg_we,
    input  logic                     cfg_sel,
    input  logic [31:0]              cfg_wdata
);
    import lsu_pkg::*;

    logic            unit_sel, bus_idle, fifo_full, fifo_empty, last_unit;
    logic            req_scratch, req_bus, req_we, push, pop;
    logic [31:0]     addr, req_wdata, scratch_rdata, bridge_rdata;
    logic [3:0]      req_be;
    logic            scratch_rvalid, bridge_rvalid, head_unit;
    logic [2:0]      head_fn3;
    logic [1:0]      head_off;
    logic [id_w-1:0] head_id;

    lsu_addr_map u_addr_map (
        .clk, .arst_n, .cfg_we, .cfg_sel, .cfg_wdata, .addr, .unit_sel
    );

    lsu_issue_ctrl u_issue_ctrl (
        .clk, .arst_n, .issue_valid, .load, .store, .fn3, .rs1, .offset, .rs2, .id,
        .issue_ready, .exc_valid, .exc_code, .exc_tval, .exc_id, .addr, .unit_sel,
        .bus_idle, .fifo_full, .fifo_empty, .last_unit, .req_scratch, .req_bus,
        .req_we, .req_be, .req_wdata, .push
    );

    lsu_load_fifo #(.fifo_depth(fifo_depth)) u_load_fifo (
        .clk, .arst_n, .push, .fn3_in(fn3), .byte_off_in(addr[1:0]), .id_in(id),
        .unit_in(unit_sel), .pop, .fn3_out(head_fn3), .byte_off_out(head_off),
        .id_out(head_id), .unit_out(head_unit), .full(fifo_full), .empty(fifo_empty),
        .last_unit
    );

    lsu_scratch_ram #(.scratch_words(scratch_words)) u_scratch_ram (
        .clk, .req(req_scratch), .we(req_we), .be(req_be), .addr, .wdata(req_wdata),
        .rdata(scratch_rdata), .rvalid(scratch_rvalid)
    );

    lsu_bus_bridge u_bus_bridge (
        .clk, .arst_n, .req(req_bus), .we(req_we), .be(req_be), .addr,
        .wdata(req_wdata), .idle(bus_idle), .rdata(bridge_rdata), .rvalid(bridge_rvalid),
        .bus_req, .bus_we, .bus_be, .bus_addr, .bus_wdata, .bus_ack, .bus_rdata
    );

    lsu_load_align u_load_align (
        .scratch_rdata, .scratch_rvalid, .bus_rdata(bridge_rdata),
        .bus_rvalid(bridge_rvalid), .fn3(head_fn3), .byte_off(head_off),
        .unit(head_unit), .id(head_id), .wb_done, .wb_data, .wb_id, .pop
    );

endmodule

// File: tb_lsu.sv
// Load/store unit testbench
`timescale 1ns/1ps

module tb_lsu;
    import lsu_pkg::*;

    logic            clk, arst_n;
    logic            issue_valid, load, store, issue_ready;
    logic [2:0]      fn3;
    logic [31:0]     rs1, rs2;
    logic [11:0]     offset;
    logic [id_w-1:0] id, exc_id, wb_id;
    logic            exc_valid, wb_done, bus_req, bus_we, bus_ack, cfg_we, cfg_sel;
    logic [3:0]      exc_code, bus_be;
    logic [31:0]     exc_tval, wb_data, bus_addr, bus_wdata, bus_rdata, cfg_wdata;

    logic [31:0]     shadow [256];
    logic [31:0]     bus_mem [logic [31:0]];
    logic [31:0]     wb_data_q [$];
    logic [id_w-1:0] wb_id_q [$];
    int              wb_cyc_q [$];
    logic [31:0]     rng;
    int              cycle, errors, checks, tests, test_start, bus_txns;
    int              accept_cycle, stall_cycles, last_latency;
    logic            exc_seen;
    logic [3:0]      exc_code_seen;
    logic [31:0]     exc_tval_seen;
    logic [id_w-1:0] exc_id_seen;

    lsu_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference models
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Contents of a bus word never written
    function automatic logic [31:0] bus_fill(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    // Pick the lane by byte offset, then extend by size code
    function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] w,
                                               input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = w[16*off[1] +: 16];
        case (f3)
            fn3_lb:  return {{24{b[7]}}, b};
            fn3_lbu: return {24'h0, b};
            fn3_lh:  return {{16{h[15]}}, h};
            fn3_lhu: return {16'h0, h};
            default: return w;
        endcase
    endfunction

    function automatic logic [31:0] merge_store(input logic [31:0] w, input logic [2:0] f3,
                                                input logic [1:0] off, input logic [31:0] d);
        logic [31:0] r;
        r = w;
        case (f3[1:0])
            2'b00:   r[8*off +: 8] = d[7:0];
            2'b01:   r[16*off[1] +: 16] = d[15:0];
            default: r = d;
        endcase
        return r;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("Verification failed");
        $finish;
    endtask

    task automatic report(input string name);
        tests++;
        if (errors == test_start) $display("test %-20s ok", name);
        else $display("test %-20s %0d mismatches", name, errors - test_start);
        test_start = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Writeback monitor and outside memory

    initial begin
        cycle = 0;
        forever begin
            @(negedge clk);
            cycle++;
            if (wb_done === 1'b1) begin
                wb_data_q.push_back(wb_data);
                wb_id_q.push_back(wb_id);
                wb_cyc_q.push_back(cycle);
            end
        end
    end

    // Four-phase responder with an ack delay of 0 to 3 cycles
    initial begin
        int          wait_cnt;
        logic [31:0] w;
        bus_ack   = 1'b0;
        bus_rdata = '0;
        bus_txns  = 0;
        forever begin
            @(negedge clk);
            if (bus_req === 1'b1) begin
                rng = xorshift32(rng);
                repeat (rng[1:0]) @(negedge clk);
                w = bus_mem.exists(bus_addr) ? bus_mem[bus_addr] : bus_fill(bus_addr);
                if (bus_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (bus_be[b]) w[8*b +: 8] = bus_wdata[8*b +: 8];
                    end
                    bus_mem[bus_addr] = w;
                end
                bus_rdata = w;
                bus_ack   = 1'b1;
                bus_txns++;
                wait_cnt = 0;
                while (bus_req === 1'b1) begin
                    @(negedge clk);
                    wait_cnt++;
                    if (wait_cnt > 20) abort_run("bus_req stayed high after bus_ack");
                end
                bus_ack = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue helpers

    // Returns just after the accepting rising edge with issue_valid still high
    task automatic issue_op(input logic ld, input logic [2:0] f3, input logic [31:0] base,
                            input logic [11:0] off, input logic [31:0] data,
                            input logic [id_w-1:0] tag);
        @(negedge clk);
        issue_valid = 1'b1;
        load        = ld;
        store       = !ld;
        fn3         = f3;
        rs1         = base;
        offset      = off;
        rs2         = data;
        id          = tag;
        stall_cycles = 0;
        #1;
        while (issue_ready !== 1'b1) begin
            stall_cycles++;
            if (stall_cycles > 100) abort_run("issue_ready stayed low for 100 cycles");
            @(negedge clk);
            #1;
        end
        accept_cycle  = cycle;
        exc_seen      = exc_valid;
        exc_code_seen = exc_code;
        exc_tval_seen = exc_tval;
        exc_id_seen   = exc_id;
        @(posedge clk);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            issue_valid = 1'b0;
            cfg_we      = 1'b0;
        end
    endtask

    task automatic wait_wb(input int n);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            issue_valid = 1'b0;
            #1;
            waited++;
            if (waited > 100) abort_run("wb_done missing after 100 cycles");
        end while (wb_data_q.size() < n);
    endtask

    task automatic store_op(input string name, input logic [2:0] f3, input logic [31:0] base,
                            input logic [11:0] off, input logic [31:0] d,
                            input logic [id_w-1:0] tag);
        logic [31:0] a;
        a = base + {{20{off[11]}}, off};
        issue_op(1'b0, f3, base, off, d, tag);
        compare({name, " exception"}, 0, exc_seen);
        if (a < 32'h400) shadow[a[9:2]] = merge_store(shadow[a[9:2]], f3, a[1:0], d);
    endtask

    task automatic load_check(input string name, input logic [2:0] f3, input logic [31:0] base,
                              input logic [11:0] off, input logic [id_w-1:0] tag,
                              input logic [31:0] expected);
        issue_op(1'b1, f3, base, off, 32'h0, tag);
        compare({name, " exception"}, 0, exc_seen);
        wait_wb(1);
        compare({name, " data"}, expected, wb_data_q.pop_front());
        compare({name, " id"}, tag, wb_id_q.pop_front());
        last_latency = wb_cyc_q.pop_front() - accept_cycle;
    endtask

    task automatic misaligned_op(input string name, input logic ld, input logic [2:0] f3,
                                 input logic [31:0] a, input logic [id_w-1:0] tag,
                                 input logic [3:0] code);
        issue_op(ld, f3, a, 12'h0, 32'hdead_beef, tag);
        compare({name, " exc_valid"}, 1, exc_seen);
        compare({name, " exc_code"}, code, exc_code_seen);
        compare({name, " exc_tval"}, a, exc_tval_seen);
        compare({name, " exc_id"}, tag, exc_id_seen);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic word_store_load();
        logic [31:0] d;
        rng = xorshift32(rng);
        d   = rng;
        // Negative offset from 0x120
        store_op("sw", fn3_lw, 32'h120, 12'hfe0, d, 3'd1);
        load_check("lw after sw", fn3_lw, 32'h100, 12'h0, 3'd2, d);
        compare("scratch load latency", 1, last_latency);
    endtask

    task automatic narrow_loads();
        store_op("sw", fn3_lw, 32'h104, 12'h0, 32'h80f7_7f01, 3'd3);
        for (int off = 0; off < 4; off++) begin
            load_check($sformatf("lb off %0d", off), fn3_lb, 32'h104, 12'(off), 3'd4,
                       load_value(fn3_lb, shadow[65], 2'(off)));
            load_check($sformatf("lbu off %0d", off), fn3_lbu, 32'h104, 12'(off), 3'd5,
                       load_value(fn3_lbu, shadow[65], 2'(off)));
        end
        for (int off = 0; off < 4; off += 2) begin
            load_check($sformatf("lh off %0d", off), fn3_lh, 32'h104, 12'(off), 3'd6,
                       load_value(fn3_lh, shadow[65], 2'(off)));
            load_check($sformatf("lhu off %0d", off), fn3_lhu, 32'h104, 12'(off), 3'd7,
                       load_value(fn3_lhu, shadow[65], 2'(off)));
        end
    endtask

    task automatic partial_stores();
        store_op("sw", fn3_lw, 32'h108, 12'h0, 32'h1122_3344, 3'd5);
        store_op("sb", fn3_lb, 32'h109, 12'h0, 32'h5555_55ab, 3'd6);
        store_op("sh", fn3_lh, 32'h10a, 12'h0, 32'haaaa_cdef, 3'd7);
        load_check("lw after sb sh", fn3_lw, 32'h108, 12'h0, 3'd0, shadow[66]);
        store_op("sb", fn3_lb, 32'h10b, 12'h0, 32'h0000_0099, 3'd1);
        store_op("sh", fn3_lh, 32'h108, 12'h0, 32'h0000_7e3c, 3'd2);
        load_check("lw after sh low", fn3_lw, 32'h108, 12'h0, 3'd3, shadow[66]);
    endtask

    task automatic misaligned_accesses();
        misaligned_op("lh", 1'b1, fn3_lh, 32'h101, 3'd3, exc_load_misaligned);
        misaligned_op("lw", 1'b1, fn3_lw, 32'h106, 3'd4, exc_load_misaligned);
        misaligned_op("sh", 1'b0, fn3_lh, 32'h109, 3'd5, exc_store_misaligned);
        misaligned_op("sw", 1'b0, fn3_lw, 32'h103, 3'd6, exc_store_misaligned);
        // Short window to catch a stray writeback
        idle_cycles(4);
        compare("wb after misaligned", 0, wb_data_q.size());
        load_check("lw 0x100 unchanged", fn3_lw, 32'h100, 12'h0, 3'd7, shadow[64]);
        load_check("lw 0x104 unchanged", fn3_lw, 32'h104, 12'h0, 3'd0, shadow[65]);
        load_check("lw 0x108 unchanged", fn3_lw, 32'h108, 12'h0, 3'd1, shadow[66]);
    endtask

    task automatic bus_accesses();
        logic [31:0] d;
        int          txns;
        txns = bus_txns;
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            d   = rng;
            store_op("bus sw", fn3_lw, 32'h8000_0100 + 4 * i, 12'h0, d, 3'(i));
            // Negative offsets reach back from 0x8000_0110
            load_check("bus lw", fn3_lw, 32'h8000_0110, 12'(4 * i - 16), 3'(i + 4), d);
        end
        load_check("bus lw fill", fn3_lw, 32'h8000_0200, 12'h0, 3'd4,
                   bus_fill(32'h8000_0200));
        store_op("bus sb", fn3_lb, 32'h8000_0102, 12'h0, 32'h0000_005a, 3'd5);
        load_check("bus lbu", fn3_lbu, 32'h8000_0102, 12'h0, 3'd6, 32'h0000_005a);
        load_check("bus lh", fn3_lh, 32'h8000_0202, 12'h0, 3'd7,
                   load_value(fn3_lh, bus_fill(32'h8000_0200), 2'd2));
        compare("bus transactions", txns + 12, bus_txns);
    endtask

    task automatic remap_and_order();
        int txns;
        // Move the bus base down to 0x400
        @(negedge clk);
        issue_valid = 1'b0;
        cfg_we      = 1'b1;
        cfg_sel     = 1'b1;
        cfg_wdata   = 32'h0000_0400;
        idle_cycles(1);
        txns = bus_txns;
        issue_op(1'b1, fn3_lhu, 32'h100, 12'h2, 32'h0, 3'd1);
        issue_op(1'b1, fn3_lw, 32'h480, 12'h0, 32'h0, 3'd2);
        compare("unit switch stall", 1, stall_cycles > 0);
        wait_wb(2);
        compare("first id", 1, wb_id_q.pop_front());
        compare("first data", load_value(fn3_lhu, shadow[64], 2'd2), wb_data_q.pop_front());
        compare("second id", 2, wb_id_q.pop_front());
        compare("second data", bus_fill(32'h0000_0480), wb_data_q.pop_front());
        wb_cyc_q.delete();
        compare("remapped bus transactions", txns + 1, bus_txns);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        tests = 0;
        test_start = 0;
        rng = 32'd67254;
        arst_n = 1'b0;
        issue_valid = 1'b0;
        load = 1'b0;
        store = 1'b0;
        fn3 = 3'b0;
        rs1 = '0;
        offset = '0;
        rs2 = '0;
        id = '0;
        cfg_we = 1'b0;
        cfg_sel = 1'b0;
        cfg_wdata = '0;
        repeat (8) @(negedge clk);
        compare("reset issue_ready", 0, issue_ready);
        compare("reset wb_done", 0, wb_done);
        compare("reset exc_valid", 0, exc_valid);
        compare("reset bus_req", 0, bus_req);
        arst_n = 1'b1;
        report("reset");
        word_store_load();
        report("word_store_load");
        narrow_loads();
        report("narrow_loads");
        partial_stores();
        report("partial_stores");
        misaligned_accesses();
        report("misaligned");
        bus_accesses();
        report("bus_accesses");
        remap_and_order();
        report("remap_and_order");
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: project.f
lsu_pkg.sv
lsu_addr_map.sv
lsu_issue_ctrl.sv
lsu_load_fifo.sv
lsu_scratch_ram.sv
lsu_bus_bridge.sv
lsu_load_align.sv
lsu_top.sv
tb_lsu.sv

// File: run.sh
#!/usr/bin/env bash
# Build the LSU testbench with Verilator, run it, and search the log for the result

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f project.f -o tb_lsu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Verification passed" sim.log; then
    exit 0
fi
exit 1
